// File: ipf_pkg.sv
package ipf_pkg;

    localparam int PIC_SIZE   = 128;
    localparam int ADDR_W     = 14;
    localparam int BAND_SHIFT = 3;   // 32 bands of 8 levels

    typedef logic [7:0]        pixel_t;
    typedef logic [ADDR_W-1:0] addr_t;   // row * PIC_SIZE + column

    // Codes 2 and 3 both select the horizontal edge class
    typedef enum logic [1:0] {
        MODE_OFF  = 2'd0,
        MODE_BAND = 2'd1,
        MODE_EDGE = 2'd2
    } ipf_mode_e;

    // Code 3 decodes as 64 as well
    typedef enum logic [1:0] {
        LCU_16 = 2'd0,
        LCU_32 = 2'd1,
        LCU_64 = 2'd2
    } lcu_size_e;

    typedef struct packed {
        logic [3:0]        off0;
        logic [3:0]        off1;
        logic signed [3:0] off2;
        logic signed [3:0] off3;
    } ipf_offsets_t;

    // One pixel in flight with its LCU configuration
    typedef struct packed {
        ipf_mode_e    mode;
        logic [4:0]   band_pos;
        ipf_offsets_t offsets;
        pixel_t       pixel;
        addr_t        addr;
        logic         row_start;
        logic         row_end;
    } ipf_beat_t;

    // Index 0/1 add unsigned and saturate, 2/3 add signed and clamp
    function automatic pixel_t apply_offset(pixel_t pix, logic [1:0] idx, ipf_offsets_t offs);
        logic [3:0]        uoff;
        logic signed [3:0] soff;
        logic [8:0]        usum;
        logic signed [9:0] ssum;
        uoff = idx[0] ? offs.off1 : offs.off0;
        soff = idx[0] ? offs.off3 : offs.off2;
        usum = {1'b0, pix} + {5'd0, uoff};
        ssum = $signed({2'b00, pix}) + $signed({{6{soff[3]}}, soff});
        if (!idx[1]) begin
            return usum[8] ? 8'hff : usum[7:0];
        end
        if (ssum < 10'sd0) begin
            return 8'h00;
        end
        if (ssum > 10'sd255) begin
            return 8'hff;
        end
        return ssum[7:0];
    endfunction

endpackage

// File: ipf_intake.sv
`timescale 1ns/1ps

module ipf_intake (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_en,
    input  ipf_pkg::pixel_t       din,
    input  ipf_pkg::ipf_mode_e    ipf_type,
    input  logic [4:0]            ipf_band_pos,
    input  ipf_pkg::ipf_offsets_t ipf_offset,
    input  logic [2:0]            lcu_x,
    input  logic [2:0]            lcu_y,
    input  ipf_pkg::lcu_size_e    lcu_size,
    output logic                  busy,
    output logic                  beat_valid,
    output ipf_pkg::ipf_beat_t    beat
);
    import ipf_pkg::*;

    // LCU configuration, captured with its first pixel
    ipf_mode_e    mode_q;
    logic [4:0]   band_pos_q;
    ipf_offsets_t offsets_q;
    logic [2:0]   lcu_x_q;
    logic [2:0]   lcu_y_q;
    lcu_size_e    size_q;

    logic [5:0]   col;
    logic [5:0]   row;

    logic         first;
    ipf_mode_e    cur_mode;
    logic [4:0]   cur_band_pos;
    ipf_offsets_t cur_offsets;
    logic [2:0]   cur_x;
    logic [2:0]   cur_y;
    lcu_size_e    cur_size;
    logic         is_edge;
    logic [5:0]   side_m1;
    logic [6:0]   x_base;
    logic [6:0]   y_base;
    logic [6:0]   col_abs;
    logic [6:0]   row_abs;
    logic         col_last;
    addr_t        addr;

    assign first        = (col == 6'd0) && (row == 6'd0);
    assign cur_mode     = first ? ipf_type     : mode_q;
    assign cur_band_pos = first ? ipf_band_pos : band_pos_q;
    assign cur_offsets  = first ? ipf_offset   : offsets_q;
    assign cur_x        = first ? lcu_x        : lcu_x_q;
    assign cur_y        = first ? lcu_y        : lcu_y_q;
    assign cur_size     = first ? lcu_size     : size_q;
    assign is_edge      = !(cur_mode == MODE_OFF || cur_mode == MODE_BAND);

    // Side is a power of two, so the LCU origin is a shift
    always_comb begin
        case (cur_size)
            LCU_16: begin
                side_m1 = 6'd15;
                x_base  = {cur_x, 4'b0};
                y_base  = {cur_y, 4'b0};
            end
            LCU_32: begin
                side_m1 = 6'd31;
                x_base  = {cur_x[1:0], 5'b0};
                y_base  = {cur_y[1:0], 5'b0};
            end
            default: begin
                side_m1 = 6'd63;
                x_base  = {cur_x[0], 6'b0};
                y_base  = {cur_y[0], 6'b0};
            end
        endcase
    end

    assign col_last = (col == side_m1);
    assign col_abs  = x_base + {1'b0, col};
    assign row_abs  = y_base + {1'b0, row};
    assign addr     = addr_t'(row_abs) * addr_t'(PIC_SIZE) + addr_t'(col_abs);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            col        <= 6'd0;
            row        <= 6'd0;
            busy       <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= in_en;
            busy       <= in_en && is_edge && col_last;   // Flush slot for the edge path
            if (in_en) begin
                if (col_last) begin
                    col <= 6'd0;
                    row <= (row == side_m1) ? 6'd0 : row + 6'd1;
                end else begin
                    col <= col + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_en) begin
            if (first) begin
                mode_q     <= ipf_type;
                band_pos_q <= ipf_band_pos;
                offsets_q  <= ipf_offset;
                lcu_x_q    <= lcu_x;
                lcu_y_q    <= lcu_y;
                size_q     <= lcu_size;
            end
            beat.mode      <= cur_mode;
            beat.band_pos  <= cur_band_pos;
            beat.offsets   <= cur_offsets;
            beat.pixel     <= din;
            beat.addr      <= addr;
            beat.row_start <= (col == 6'd0);
            beat.row_end   <= col_last;
        end
    end

endmodule

// File: ipf_band_offset.sv
`timescale 1ns/1ps

module ipf_band_offset (
    input  logic               clk,
    input  logic               reset,
    input  logic               beat_valid,
    input  ipf_pkg::ipf_beat_t beat,
    output logic               res_valid,
    output ipf_pkg::pixel_t    res_pixel,
    output ipf_pkg::addr_t     res_addr
);
    import ipf_pkg::*;

    logic       take;
    logic [4:0] band;
    logic       in_window;
    pixel_t     result;

    // Off and band beats both come through here
    assign take = beat_valid && (beat.mode == MODE_OFF || beat.mode == MODE_BAND);
    assign band = 5'(beat.pixel >> BAND_SHIFT);

    // Window around band_pos does not wrap at 0 or 31
    assign in_window = (band == beat.band_pos)
                    || (beat.band_pos != 5'd0  && band == beat.band_pos - 5'd1)
                    || (beat.band_pos != 5'd31 && band == beat.band_pos + 5'd1);

    always_comb begin
        if (beat.mode == MODE_BAND && !in_window) begin
            result = apply_offset(beat.pixel, band[1:0], beat.offsets);   // Band mod 4
        end else begin
            result = beat.pixel;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res_pixel <= result;
            res_addr  <= beat.addr;
        end
    end

endmodule

// File: ipf_edge_offset.sv
`timescale 1ns/1ps

module ipf_edge_offset (
    input  logic               clk,
    input  logic               reset,
    input  logic               beat_valid,
    input  ipf_pkg::ipf_beat_t beat,
    output logic               res_valid,
    output ipf_pkg::pixel_t    res_pixel,
    output ipf_pkg::addr_t     res_addr
);
    import ipf_pkg::*;

    logic       take;
    ipf_beat_t  centre_q;       // Waiting for its right neighbour
    logic       centre_valid;
    pixel_t     left_q;
    logic       flush_q;        // Row end seen, last pixel still held
    pixel_t     a;
    pixel_t     b;
    pixel_t     c;
    logic [8:0] twice_c;
    logic [8:0] sum_ab;
    pixel_t     filtered;

    assign take = beat_valid && !(beat.mode == MODE_OFF || beat.mode == MODE_BAND);

    assign a       = left_q;
    assign b       = beat.pixel;
    assign c       = centre_q.pixel;
    assign twice_c = {c, 1'b0};
    assign sum_ab  = {1'b0, a} + {1'b0, b};

    always_comb begin
        if (centre_q.row_start) begin
            filtered = c;   // First pixel of a row has no left neighbour
        end else if (c < a && c < b) begin
            filtered = apply_offset(c, 2'd0, centre_q.offsets);   // Valley
        end else if (c > a && c > b) begin
            filtered = apply_offset(c, 2'd3, centre_q.offsets);   // Peak
        end else if (twice_c < sum_ab) begin
            filtered = apply_offset(c, 2'd1, centre_q.offsets);
        end else if (twice_c > sum_ab) begin
            filtered = apply_offset(c, 2'd2, centre_q.offsets);
        end else begin
            filtered = c;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            centre_valid <= 1'b0;
            flush_q      <= 1'b0;
            res_valid    <= 1'b0;
        end else begin
            res_valid <= (take && centre_valid) || flush_q;
            flush_q   <= take && beat.row_end;
            if (take) begin
                centre_valid <= 1'b1;
            end else if (flush_q) begin
                centre_valid <= 1'b0;   // Next row starts with an empty window
            end
        end
    end

    // Flush falls in the intake's busy cycle, so it never meets a new beat
    always_ff @(posedge clk) begin
        if (take) begin
            centre_q <= beat;
            left_q   <= centre_q.pixel;
            if (centre_valid) begin
                res_pixel <= filtered;
                res_addr  <= centre_q.addr;
            end
        end else if (flush_q) begin
            res_pixel <= centre_q.pixel;   // Last pixel of the row
            res_addr  <= centre_q.addr;
        end
    end

endmodule

// File: ipf_output.sv
`timescale 1ns/1ps

module ipf_output (
    input  logic            clk,
    input  logic            reset,
    input  logic            band_valid,
    input  ipf_pkg::pixel_t band_pixel,
    input  ipf_pkg::addr_t  band_addr,
    input  logic            edge_valid,
    input  ipf_pkg::pixel_t edge_pixel,
    input  ipf_pkg::addr_t  edge_addr,
    output logic            out_en,
    output ipf_pkg::pixel_t dout,
    output ipf_pkg::addr_t  dout_addr,
    output logic            finish
);
    import ipf_pkg::*;

    localparam addr_t LAST_ADDR = addr_t'(PIC_SIZE * PIC_SIZE - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_en    <= 1'b0;
            dout      <= 8'd0;
            dout_addr <= '0;
            finish    <= 1'b0;
        end else begin
            out_en <= band_valid || edge_valid;
            finish <= out_en && (dout_addr == LAST_ADDR);   // Bottom right pixel just left
            // The two paths are never valid together
            if (edge_valid) begin
                dout      <= edge_pixel;
                dout_addr <= edge_addr;
            end else if (band_valid) begin
                dout      <= band_pixel;
                dout_addr <= band_addr;
            end
        end
    end

endmodule

// File: ipf_top.sv
`timescale 1ns/1ps

module ipf_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_en,
    input  ipf_pkg::pixel_t       din,
    input  ipf_pkg::ipf_mode_e    ipf_type,
    input  logic [4:0]            ipf_band_pos,
    input  ipf_pkg::ipf_offsets_t ipf_offset,
    input  logic [2:0]            lcu_x,
    input  logic [2:0]            lcu_y,
    input  ipf_pkg::lcu_size_e    lcu_size,
    output logic                  busy,
    output logic                  out_en,
    output ipf_pkg::pixel_t       dout,
    output ipf_pkg::addr_t        dout_addr,
    output logic                  finish
);
    import ipf_pkg::*;

    logic      beat_valid;
    ipf_beat_t beat;
    logic      band_valid;
    pixel_t    band_pixel;
    addr_t     band_addr;
    logic      edge_valid;
    pixel_t    edge_pixel;
    addr_t     edge_addr;

    ipf_intake intake_i (
        .clk, .reset, .in_en, .din, .ipf_type, .ipf_band_pos, .ipf_offset,
        .lcu_x, .lcu_y, .lcu_size, .busy, .beat_valid, .beat
    );

    ipf_band_offset band_i (
        .clk, .reset, .beat_valid, .beat,
        .res_valid(band_valid), .res_pixel(band_pixel), .res_addr(band_addr)
    );

    ipf_edge_offset edge_i (
        .clk, .reset, .beat_valid, .beat,
        .res_valid(edge_valid), .res_pixel(edge_pixel), .res_addr(edge_addr)
    );

    ipf_output output_i (
        .clk, .reset, .band_valid, .band_pixel, .band_addr,
        .edge_valid, .edge_pixel, .edge_addr,
        .out_en, .dout, .dout_addr, .finish
    );

endmodule

// File: ipf_tb_clk.sv
`timescale 1ns/1ps

module ipf_tb_clk (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    // Held over two rising edges
    initial begin
        reset = 1'b0;
        #1 reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: ipf_chk.sv
`timescale 1ns/1ps

module ipf_chk (
    input logic clk,
    input logic reset,
    input logic in_en,
    input logic busy,
    input logic out_en,
    input logic finish
);

    // Busy marks one flush slot per row
    busy_single: assert property (@(posedge clk) disable iff (reset) busy |=> !busy)
        else $error("busy stayed high for two cycles");

    busy_blocks_input: assert property (@(posedge clk) disable iff (reset) busy |-> !in_en)
        else $error("in_en was high while busy was high");

    reset_quiet: assert property (@(posedge clk) reset |-> !out_en && !busy && !finish)
        else $error("out_en, busy or finish active during reset");

    finish_after_out: assert property (
        @(posedge clk) disable iff (reset) finish |-> $past(out_en)
    ) else $error("finish rose without an output in the cycle before");

endmodule

bind ipf_top ipf_chk chk_i (
    .clk, .reset, .in_en, .busy, .out_en, .finish
);

// File: ipf_tb.sv
`timescale 1ns/1ps

module ipf_tb;
    import ipf_pkg::*;

    localparam int         NUM_TESTS  = 13;
    localparam logic [1:0] PAT_RAMP   = 2'd0;
    localparam logic [1:0] PAT_RANDOM = 2'd1;
    localparam logic [1:0] PAT_CRAFT  = 2'd2;   // Peaks, valleys, slopes and flats

    typedef struct packed {
        logic [1:0]   mode;
        logic [1:0]   size;
        logic [2:0]   x;
        logic [2:0]   y;
        logic [4:0]   band_pos;
        ipf_offsets_t offsets;
        logic [1:0]   pattern;
        logic         gaps;       // Idle source cycles between pixels
    } test_t;

    typedef struct packed {
        pixel_t     pixel;
        addr_t      addr;
        logic [3:0] test;
    } expect_t;

    logic         clk;
    logic         reset;
    logic         in_en;
    pixel_t       din;
    ipf_mode_e    ipf_type;
    logic [4:0]   ipf_band_pos;
    ipf_offsets_t ipf_offset;
    logic [2:0]   lcu_x;
    logic [2:0]   lcu_y;
    lcu_size_e    lcu_size;
    logic         busy;
    logic         out_en;
    pixel_t       dout;
    addr_t        dout_addr;
    logic         finish;

    test_t   tests[NUM_TESTS];
    string   names[NUM_TESTS];
    int      errors[NUM_TESTS];
    int      pending[NUM_TESTS];
    int      num_added = 0;
    int      other_errors = 0;
    int      checks = 0;
    int      finish_count = 0;
    int      cycles = 0;
    int      cycle_limit = 0;
    expect_t exp_q[$];
    expect_t head;
    pixel_t  lcu_pix[4096];
    addr_t   last_addr = '0;

    ipf_tb_clk clk_gen_i (.clk, .reset);

    ipf_top ipf_top_i (
        .clk, .reset, .in_en, .din, .ipf_type, .ipf_band_pos, .ipf_offset,
        .lcu_x, .lcu_y, .lcu_size, .busy, .out_en, .dout, .dout_addr, .finish
    );

    task automatic add_test(input string name, input logic [1:0] mode, input logic [1:0] size,
                            input logic [2:0] x, input logic [2:0] y, input logic [4:0] band_pos,
                            input logic [15:0] offsets, input logic [1:0] pattern,
                            input logic gaps);
        tests[num_added] = {mode, size, x, y, band_pos, offsets, pattern, gaps};
        names[num_added] = name;
        num_added++;
    endtask

    // Offsets are off0, off1 unsigned and off2, off3 signed, top nibble first
    task automatic build_table();
        add_test("off_16",       2'd0, 2'd0, 3'd3, 3'd5, 5'd0,  16'h0000, PAT_RAMP,   1'b0);
        add_test("off_32_gaps",  2'd0, 2'd1, 3'd2, 3'd1, 5'd0,  16'h0000, PAT_RANDOM, 1'b1);
        add_test("off_64",       2'd0, 2'd2, 3'd1, 3'd0, 5'd0,  16'h0000, PAT_RAMP,   1'b0);
        add_test("band_mid",     2'd1, 2'd0, 3'd1, 3'd0, 5'd12, 16'h59d8, PAT_RANDOM, 1'b1);
        add_test("band_pos_0",   2'd1, 2'd1, 3'd0, 3'd0, 5'd0,  16'hff87, PAT_RAMP,   1'b0);
        add_test("band_pos_31",  2'd1, 2'd0, 3'd4, 3'd2, 5'd31, 16'h3777, PAT_RAMP,   1'b0);
        add_test("edge_crafted", 2'd2, 2'd0, 3'd5, 3'd3, 5'd0,  16'hf4e8, PAT_CRAFT,  1'b0);
        add_test("edge_32_gaps", 2'd2, 2'd1, 3'd3, 3'd2, 5'd0,  16'h6a97, PAT_RANDOM, 1'b1);
        add_test("edge_64",      2'd3, 2'd3, 3'd0, 3'd1, 5'd0,  16'h21f1, PAT_RANDOM, 1'b0);
        add_test("band_64",      2'd1, 2'd2, 3'd1, 3'd0, 5'd20, 16'hc3a6, PAT_RANDOM, 1'b0);
        add_test("off_16_b",     2'd0, 2'd0, 3'd2, 3'd7, 5'd0,  16'h0000, PAT_RANDOM, 1'b0);
        add_test("edge_32_b",    2'd2, 2'd1, 3'd2, 3'd3, 5'd0,  16'h8f7c, PAT_CRAFT,  1'b1);
        add_test("finish_16",    2'd1, 2'd0, 3'd7, 3'd7, 5'd16, 16'h4321, PAT_RAMP,   1'b0);
    endtask

    function automatic int side_of(input logic [1:0] size);
        case (size)
            2'd0:    return 16;
            2'd1:    return 32;
            default: return 64;
        endcase
    endfunction

    function automatic pixel_t model_offset(input pixel_t pix, input int idx,
                                            input ipf_offsets_t offs);
        int v;
        case (idx)
            0:       v = int'(pix) + int'(offs.off0);
            1:       v = int'(pix) + int'(offs.off1);
            2:       v = int'(pix) + int'(offs.off2);
            default: v = int'(pix) + int'(offs.off3);
        endcase
        if (v > 255) begin
            v = 255;
        end else if (v < 0) begin
            v = 0;
        end
        return pixel_t'(v);
    endfunction

    function automatic pixel_t band_expect(input pixel_t pix, input test_t t);
        int band;
        int bp;
        band = int'(pix) / 8;
        bp   = int'(t.band_pos);
        if (band >= bp - 1 && band <= bp + 1)
            return pix;
        return model_offset(pix, band % 4, t.offsets);
    endfunction

    function automatic pixel_t edge_expect(input int a, input int c, input int b,
                                           input ipf_offsets_t offs);
        if (c < a && c < b)
            return model_offset(pixel_t'(c), 0, offs);
        if (c > a && c > b)
            return model_offset(pixel_t'(c), 3, offs);
        if (2 * c < a + b)
            return model_offset(pixel_t'(c), 1, offs);
        if (2 * c > a + b)
            return model_offset(pixel_t'(c), 2, offs);
        return pixel_t'(c);
    endfunction

    function automatic pixel_t expect_pixel(input test_t t, input int row, input int col,
                                            input int side);
        int     i;
        pixel_t c;
        i = row * side + col;
        c = lcu_pix[i];
        if (t.mode == 2'd0)
            return c;
        if (t.mode == 2'd1)
            return band_expect(c, t);
        if (col == 0 || col == side - 1)
            return c;   // Row ends have one neighbour only
        return edge_expect(int'(lcu_pix[i - 1]), int'(c), int'(lcu_pix[i + 1]), t.offsets);
    endfunction

    function automatic pixel_t craft_pixel(input int row, input int col);
        pixel_t pat[16];
        pat = '{8'd255, 8'd250, 8'd255, 8'd0, 8'd3, 8'd0, 8'd100, 8'd90,
                8'd95, 8'd120, 8'd130, 8'd125, 8'd60, 8'd60, 8'd60, 8'd200};
        return pat[(row + col) % 16];
    endfunction

    task automatic fill_lcu(input test_t t, input int side);
        for (int i = 0; i < side * side; i++) begin
            case (t.pattern)
                PAT_RAMP:   lcu_pix[i] = pixel_t'(i);
                PAT_RANDOM: lcu_pix[i] = pixel_t'($urandom);
                default:    lcu_pix[i] = craft_pixel(i / side, i % side);
            endcase
        end
    endtask

    task automatic queue_expected(input int tidx, input int side);
        test_t   t;
        expect_t e;
        t = tests[tidx];
        for (int row = 0; row < side; row++) begin
            for (int col = 0; col < side; col++) begin
                e.pixel = expect_pixel(t, row, col, side);
                e.addr  = addr_t'((int'(t.y) * side + row) * PIC_SIZE + int'(t.x) * side + col);
                e.test  = 4'(tidx);
                exp_q.push_back(e);
            end
        end
        pending[tidx] = side * side;
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic drive_pixel(input pixel_t p, input logic gaps);
        if (gaps && $urandom % 4 == 0) begin
            in_en = 1'b0;
            @(posedge clk);
            #1;
        end
        while (busy) begin
            in_en = 1'b0;
            @(posedge clk);
            #1;
        end
        in_en = 1'b1;
        din   = p;
        @(posedge clk);
        #1;
        in_en = 1'b0;
    endtask

    task automatic run_test(input int tidx);
        test_t t;
        int    side;
        int    busy_seen;
        int    busy_expect;
        t         = tests[tidx];
        side      = side_of(t.size);
        busy_seen = 0;
        fill_lcu(t, side);
        queue_expected(tidx, side);
        ipf_type     = ipf_mode_e'(t.mode);
        ipf_band_pos = t.band_pos;
        ipf_offset   = t.offsets;
        lcu_x        = t.x;
        lcu_y        = t.y;
        lcu_size     = lcu_size_e'(t.size);
        for (int i = 0; i < side * side; i++) begin
            drive_pixel(lcu_pix[i], t.gaps);
            if (busy)
                busy_seen++;
        end
        busy_expect = t.mode[1] ? side : 0;   // One flush per row in edge mode
        assert (busy_seen == busy_expect) else begin
            $display("mismatch %s busy pulses: expected %0d actual %0d",
                     names[tidx], busy_expect, busy_seen);
            errors[tidx]++;
        end
    endtask

    // Outputs settle after the rising edge
    always @(negedge clk) begin
        if (!reset && finish) begin
            finish_count++;
            assert (last_addr == 14'd16383) else begin
                $display("finish pulsed after address %0d instead of the last picture address",
                         last_addr);
                other_errors++;
            end
        end
        if (!reset && out_en) begin
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("output at address %0d arrived with no pixel left to expect", dout_addr);
                other_errors++;
            end
            if (exp_q.size() > 0) begin
                head = exp_q.pop_front();
                assert (dout == head.pixel) else begin
                    $display("mismatch %s pixel at %0d: expected %0d actual %0d",
                             names[head.test], head.addr, head.pixel, dout);
                    errors[head.test]++;
                end
                assert (dout_addr == head.addr) else begin
                    $display("mismatch %s address: expected %0d actual %0d",
                             names[head.test], head.addr, dout_addr);
                    errors[head.test]++;
                end
                last_addr = dout_addr;
                pending[head.test]--;
                if (pending[head.test] == 0)
                    $display("test %0d %s: %0d pixels checked, %0d errors", head.test,
                             names[head.test], side_of(tests[head.test].size) ** 2,
                             errors[head.test]);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d outputs still missing", cycles, exp_q.size());
            $display("test failed");
            $finish;
        end
    end

    initial begin
        int side;
        int total_errors;
        void'($urandom(32'hd49f_ba6e));
        in_en        = 1'b0;
        din          = '0;
        ipf_type     = MODE_OFF;
        ipf_band_pos = '0;
        ipf_offset   = '0;
        lcu_x        = '0;
        lcu_y        = '0;
        lcu_size     = LCU_16;
        build_table();
        cycle_limit = 200;
        for (int i = 0; i < NUM_TESTS; i++) begin
            side        = side_of(tests[i].size);
            cycle_limit += side * side + 2 * side;
            if (tests[i].gaps)
                cycle_limit += side * side;   // At most one idle cycle per pixel
            errors[i]  = 0;
            pending[i] = 0;
        end
        wait (reset == 1'b1);
        wait (reset == 1'b0);
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_TESTS; i++)
            run_test(i);
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);
        assert (finish_count == 1) else begin
            $display("finish pulsed %0d times, expected exactly once", finish_count);
            other_errors++;
        end
        total_errors = other_errors;
        for (int i = 0; i < NUM_TESTS; i++)
            total_errors += errors[i];
        $display("tests %0d, outputs checked %0d, errors %0d", NUM_TESTS, checks, total_errors);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: compile.f
ipf_pkg.sv
ipf_intake.sv
ipf_band_offset.sv
ipf_edge_offset.sv
ipf_output.sv
ipf_top.sv
ipf_tb_clk.sv
ipf_chk.sv
ipf_tb.sv

// File: Makefile
TOP = ipf_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f compile.f -o ipf_sim
	./obj_dir/ipf_sim | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
